// File: vlog.f
source/uart_cfg_pkg.sv
source/uart_data_pkg.sv
source/uart_baud_gen.sv
source/uart_sync_fifo.sv
source/uart_rx_fsm.sv
source/uart_tx_fsm.sv
source/uart_core.sv
bench/uart_clk_gen.sv
bench/uart_core_tb.sv

// File: bench/uart_core_tb.sv
`timescale 1ns/1ps
// testbench for uart_core in loopback and against a bit level line model
// receive results are checked by concurrent assertions against a queue
// run length is capped by a cycle limit derived from the test frames

module uart_core_tb
   import uart_cfg_pkg::*, uart_data_pkg::*;
;

   localparam int TX_DEPTH   = 8;
   localparam int RX_DEPTH   = 8;
   localparam int BAUD_DIV   = 1;
   localparam int BIT_CYCLES = 16 * (BAUD_DIV + 1);
   localparam int PAR_FRAMES = 12;
   // every frame of every test, longest format is 12 bits
   localparam int FRAMES     = 32 + 2 * PAR_FRAMES + 4 + 2 + (RX_DEPTH + 2) + 20;
   // settle gaps and reset as extra bit times
   localparam int LIMIT      = (FRAMES * 12 + 60) * BIT_CYCLES;

   logic         app_clk;
   logic         reset_n;
   logic         cfg_rx_enable;
   logic         cfg_tx_enable;
   stop_mode_t   cfg_stop;
   parity_mode_t cfg_parity;
   baud_div_t    cfg_baud_div;
   logic         tx_valid;
   logic         tx_ready;
   uart_byte_t   tx_data;
   logic         rx_valid;
   logic         rx_ready;
   uart_byte_t   rx_data;
   rx_err_t      rx_err;
   logic         rx_overrun;
   logic         si;
   logic         so;

   // line model and mux
   logic         use_model;
   logic         model_si;

   // scoreboard
   rx_entry_t    exp_q[$];
   rx_entry_t    exp_head;
   int           exp_count;
   logic         ovr_expect;
   int           ovr_seen;
   logic         stall_seen;

   string        test_name;
   int           err_count;
   int           test_err_base;
   int           tests_run;
   int           cycle_cnt;

   uart_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(16)) clk_gen0 (
      .app_clk (app_clk),
      .reset_n (reset_n)
   );

   uart_core #(.TX_DEPTH(TX_DEPTH), .RX_DEPTH(RX_DEPTH)) dut0 (
      .app_clk       (app_clk),
      .reset_n       (reset_n),
      .cfg_rx_enable (cfg_rx_enable),
      .cfg_tx_enable (cfg_tx_enable),
      .cfg_stop      (cfg_stop),
      .cfg_parity    (cfg_parity),
      .cfg_baud_div  (cfg_baud_div),
      .tx_valid      (tx_valid),
      .tx_ready      (tx_ready),
      .tx_data       (tx_data),
      .rx_valid      (rx_valid),
      .rx_ready      (rx_ready),
      .rx_data       (rx_data),
      .rx_err        (rx_err),
      .rx_overrun    (rx_overrun),
      .si            (si),
      .so            (so)
   );

   // loopback or bit banged line
   assign si = use_model ? model_si : so;

   //////////////////////////////
   // reporting
   //////////////////////////////

   task automatic report_mismatch(input logic [31:0] expected, input logic [31:0] actual);
      err_count++;
      $display("[ERROR] %s: expected %0h, actual %0h", test_name, expected, actual);
   endtask

   task automatic report_failure(input string what);
      err_count++;
      $display("%s: %s", test_name, what);
   endtask

   // head of queue as seen by the assertions
   function automatic void refresh_head();
      exp_count = exp_q.size();
      exp_head  = (exp_q.size() != 0) ? exp_q[0] : '0;
   endfunction

   //////////////////////////////
   // checks
   //////////////////////////////

   a_rx_expected: assert property (@(posedge app_clk) disable iff (!reset_n)
      (rx_valid && rx_ready) |-> exp_count != 0)
      else report_failure("received a byte that was never sent");
   a_rx_value: assert property (@(posedge app_clk) disable iff (!reset_n)
      (rx_valid && rx_ready && exp_count != 0) |-> {rx_err, rx_data} == exp_head)
      else report_mismatch($sampled(exp_head), $sampled({rx_err, rx_data}));
   a_overrun: assert property (@(posedge app_clk) disable iff (!reset_n)
      rx_overrun |-> ovr_expect)
      else report_failure("overrun flagged while the receive fifo had room");

   // pop on each accepted rx transfer, count overrun pulses
   always @(posedge app_clk) begin
      if (reset_n && rx_valid && rx_ready && exp_q.size() != 0) begin
         void'(exp_q.pop_front());
         refresh_head();
      end
      if (reset_n && rx_overrun) begin
         ovr_seen++;
      end
   end

   // run limit
   always @(posedge app_clk) begin
      cycle_cnt++;
      if (cycle_cnt >= LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", LIMIT);
         $display("TEST FAIL");
         $finish;
      end
   end

   //////////////////////////////
   // stimulus helpers
   //////////////////////////////

   // parity by the frame rule, odd is the inverse of the xor
   function automatic logic parity_of(input uart_byte_t b, input parity_mode_t mode);
      return (mode == par_odd) ? ~(^b) : ^b;
   endfunction

   // host write, valid stays high after the transfer
   task automatic send_tx(input uart_byte_t b);
      logic accepted;
      accepted = 1'b0;
      tx_valid = 1'b1;
      tx_data  = b;
      while (!accepted) begin
         // tx_ready is stable from here to the next rising edge
         accepted = tx_ready;
         if (!accepted) begin
            stall_seen = 1'b1;
         end
         @(negedge app_clk);
      end
      exp_q.push_back({err_none, b});
      refresh_head();
   endtask

   task automatic drive_bit(input logic v, input int ticks);
      model_si = v;
      repeat (ticks * (BAUD_DIV + 1)) @(negedge app_clk);
   endtask

   // one frame in the current format
   task automatic drive_frame(input uart_byte_t b, input logic bad_par, input logic low_stop);
      drive_bit(1'b0, 16);
      for (int i = 0; i < 8; i++) begin
         drive_bit(b[i], 16);
      end
      if (cfg_parity != par_none) begin
         drive_bit(parity_of(b, cfg_parity) ^ bad_par, 16);
      end
      if (low_stop) begin
         // low only past the centre sample, too short for a false start
         drive_bit(1'b0, 12);
         drive_bit(1'b1, 4);
      end else begin
         drive_bit(1'b1, 16);
      end
      if (cfg_stop == stop_two) begin
         drive_bit(1'b1, 16);
      end
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) begin
         @(negedge app_clk);
      end
      // two bit times so both machines are idle
      repeat (2 * BIT_CYCLES) @(negedge app_clk);
   endtask

   task automatic begin_test(input string name);
      test_name     = name;
      test_err_base = err_count;
   endtask

   task automatic end_test();
      tests_run++;
      $display("%s finished, %0d errors", test_name, err_count - test_err_base);
   endtask

   task automatic run_loopback(input parity_mode_t par, input stop_mode_t stp, input int count);
      uart_byte_t b;
      cfg_parity = par;
      cfg_stop   = stp;
      use_model  = 1'b0;
      for (int i = 0; i < count; i++) begin
         b = uart_byte_t'($urandom);
         send_tx(b);
      end
      tx_valid = 1'b0;
      wait_drain();
   endtask

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial begin
      uart_byte_t b;
      cfg_rx_enable = 1'b1;
      cfg_tx_enable = 1'b1;
      cfg_stop      = stop_one;
      cfg_parity    = par_none;
      cfg_baud_div  = baud_div_t'(BAUD_DIV);
      tx_valid      = 1'b0;
      tx_data       = '0;
      rx_ready      = 1'b1;
      use_model     = 1'b0;
      model_si      = 1'b1;
      ovr_expect    = 1'b0;
      ovr_seen      = 0;
      stall_seen    = 1'b0;
      err_count     = 0;
      tests_run     = 0;
      cycle_cnt     = 0;
      test_name     = "reset";
      refresh_head();
      void'($urandom(32'h84bb));
      @(posedge reset_n);
      repeat (4) @(negedge app_clk);

      begin_test("loop_8n1");
      run_loopback(par_none, stop_one, 32);
      end_test();

      begin_test("loop_parity");
      run_loopback(par_even, stop_two, PAR_FRAMES);
      run_loopback(par_odd, stop_one, PAR_FRAMES);
      end_test();

      // line model from here, line is idle high on both sides
      begin_test("rx_parity");
      use_model = 1'b1;
      for (int i = 0; i < 4; i++) begin
         cfg_parity = (i < 2) ? par_even : par_odd;
         b = uart_byte_t'($urandom);
         exp_q.push_back({err_parity, b});
         refresh_head();
         drive_frame(b, 1'b1, 1'b0);
      end
      wait_drain();
      end_test();

      // framing wins over a bad parity bit
      begin_test("rx_framing");
      cfg_parity = par_even;
      for (int i = 0; i < 2; i++) begin
         b = uart_byte_t'($urandom);
         exp_q.push_back({err_frame, b});
         refresh_head();
         drive_frame(b, i[0], 1'b1);
      end
      wait_drain();
      end_test();

      begin_test("rx_overrun");
      cfg_parity = par_none;
      rx_ready   = 1'b0;
      ovr_seen   = 0;
      for (int i = 0; i < RX_DEPTH; i++) begin
         b = uart_byte_t'($urandom);
         exp_q.push_back({err_none, b});
         refresh_head();
         drive_frame(b, 1'b0, 1'b0);
      end
      // fifo is full, the next frames are dropped
      ovr_expect = 1'b1;
      for (int i = 0; i < 2; i++) begin
         drive_frame(uart_byte_t'($urandom), 1'b0, 1'b0);
      end
      repeat (BIT_CYCLES) @(negedge app_clk);
      ovr_expect = 1'b0;
      assert (ovr_seen == 2) else report_mismatch(2, ovr_seen);
      rx_ready = 1'b1;
      wait_drain();
      end_test();

      begin_test("tx_backpressure");
      stall_seen = 1'b0;
      run_loopback(par_none, stop_one, 20);
      assert (stall_seen) else report_failure("tx_ready never dropped with the fifo full");
      end_test();

      $display("tests run %0d, errors %0d", tests_run, err_count);
      if (err_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: bench/uart_clk_gen.sv
`timescale 1ns/1ps
// free running app_clk and a synchronous active low reset
// reset is released on a falling edge after RESET_CYCLES rising edges

module uart_clk_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 16
) (
   output logic app_clk,
   output logic reset_n
);

   initial begin
      app_clk = 1'b0;
      forever #(PERIOD_NS / 2) app_clk = ~app_clk;
   end

   // hold reset across the first cycles
   initial begin
      reset_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge app_clk);
      @(negedge app_clk);
      reset_n = 1'b1;
   end

endmodule

// File: source/uart_core.sv
`timescale 1ns/1ps
// uart core on a single clock with valid/ready host streams
// FIFO depths must be powers of two
// config inputs are expected stable while a frame is on the line

module uart_core
   import uart_cfg_pkg::*, uart_data_pkg::*;
#(
   parameter int TX_DEPTH = 8,
   parameter int RX_DEPTH = 8
) (
   input  logic         app_clk,
   input  logic         reset_n,
   // frame format
   input  logic         cfg_rx_enable,
   input  logic         cfg_tx_enable,
   input  stop_mode_t   cfg_stop,
   input  parity_mode_t cfg_parity,
   input  baud_div_t    cfg_baud_div,
   // host transmit stream
   input  logic         tx_valid,
   output logic         tx_ready,
   input  uart_byte_t   tx_data,
   // host receive stream
   output logic         rx_valid,
   input  logic         rx_ready,
   output uart_byte_t   rx_data,
   output rx_err_t      rx_err,
   output logic         rx_overrun,
   // line
   input  logic         si,
   output logic         so
);

   logic       baud_tick;
   logic       txq_valid;
   logic       txq_ready;
   uart_byte_t txq_data;
   logic       rxq_valid;
   logic       rxq_ready;
   rx_entry_t  rxq_data;
   rx_entry_t  rx_word;

   uart_baud_gen baud_gen0 (
      .app_clk      (app_clk),
      .reset_n      (reset_n),
      .cfg_baud_div (cfg_baud_div),
      .baud_tick    (baud_tick)
   );

   //////////////////////////////
   // transmit path
   //////////////////////////////

   uart_sync_fifo #(.WIDTH($bits(uart_byte_t)), .DEPTH(TX_DEPTH)) tx_fifo0 (
      .app_clk   (app_clk),
      .reset_n   (reset_n),
      .in_valid  (tx_valid),
      .in_ready  (tx_ready),
      .in_data   (tx_data),
      .out_valid (txq_valid),
      .out_ready (txq_ready),
      .out_data  (txq_data)
   );

   uart_tx_fsm tx_fsm0 (
      .app_clk       (app_clk),
      .reset_n       (reset_n),
      .baud_tick     (baud_tick),
      .cfg_tx_enable (cfg_tx_enable),
      .cfg_stop      (cfg_stop),
      .cfg_parity    (cfg_parity),
      .rd_valid      (txq_valid),
      .rd_ready      (txq_ready),
      .rd_data       (txq_data),
      .so            (so)
   );

   //////////////////////////////
   // receive path
   //////////////////////////////

   uart_rx_fsm rx_fsm0 (
      .app_clk       (app_clk),
      .reset_n       (reset_n),
      .baud_tick     (baud_tick),
      .cfg_rx_enable (cfg_rx_enable),
      .cfg_stop      (cfg_stop),
      .cfg_parity    (cfg_parity),
      .si            (si),
      .wr_valid      (rxq_valid),
      .wr_ready      (rxq_ready),
      .wr_data       (rxq_data),
      .rx_overrun    (rx_overrun)
   );

   uart_sync_fifo #(.WIDTH($bits(rx_entry_t)), .DEPTH(RX_DEPTH)) rx_fifo0 (
      .app_clk   (app_clk),
      .reset_n   (reset_n),
      .in_valid  (rxq_valid),
      .in_ready  (rxq_ready),
      .in_data   (rxq_data),
      .out_valid (rx_valid),
      .out_ready (rx_ready),
      .out_data  (rx_word)
   );

   // split fifo word into byte and status
   assign rx_data = rx_word[7:0];
   assign rx_err  = rx_err_t'(rx_word[9:8]);

endmodule

// File: source/uart_tx_fsm.sv
`timescale 1ns/1ps
// transmit machine on the 16x baud enable
// every bit lasts 16 ticks and the next byte follows the last stop
// parity sense is taken when the byte is loaded

module uart_tx_fsm
   import uart_cfg_pkg::*, uart_data_pkg::*;
(
   input  logic         app_clk,
   input  logic         reset_n,
   input  logic         baud_tick,
   input  logic         cfg_tx_enable,
   input  stop_mode_t   cfg_stop,
   input  parity_mode_t cfg_parity,
   input  logic         rd_valid,
   output logic         rd_ready,
   input  uart_byte_t   rd_data,
   output logic         so
);

   typedef enum logic [2:0] {idle, start, data, parity, stop1, stop2} tx_state_t;

   tx_state_t  state;
   logic [3:0] tick_cnt;
   logic [2:0] bit_cnt;
   uart_byte_t shift_q;
   logic       par_q;
   logic       bit_end;
   logic       last_stop;
   logic       load;

   // last tick of the current bit
   assign bit_end   = baud_tick && (tick_cnt == 4'd15);
   assign last_stop = (state == stop2) || ((state == stop1) && (cfg_stop == stop_one));
   // start from idle on any tick or back to back after the last stop
   assign load      = cfg_tx_enable && rd_valid &&
                      (((state == idle) && baud_tick) || (last_stop && bit_end));
   // one cycle pop of the fifo head
   assign rd_ready  = load;

   // byte and parity bit
   always_ff @(posedge app_clk) begin
      if (load) begin
         shift_q <= rd_data;
         par_q   <= ^rd_data ^ (cfg_parity == par_odd);
      end else if (bit_end && ((state == start) || (state == data))) begin
         shift_q <= shift_q >> 1;
      end
   end

   //////////////////////////////
   // bit sequencer
   //////////////////////////////

   always_ff @(posedge app_clk) begin
      if (!reset_n) begin
         state    <= idle;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         so       <= 1'b1;
      end else if (load) begin
         state    <= start;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         so       <= 1'b0;
      end else if (baud_tick && (state != idle)) begin
         tick_cnt <= tick_cnt + 4'd1;
         if (bit_end) begin
            case (state)
               start: begin
                  state <= data;
                  so    <= shift_q[0];
               end
               data: begin
                  if (bit_cnt != 3'd7) begin
                     bit_cnt <= bit_cnt + 3'd1;
                     so      <= shift_q[0];
                  end else if (cfg_parity == par_none) begin
                     state <= stop1;
                     so    <= 1'b1;
                  end else begin
                     state <= parity;
                     so    <= par_q;
                  end
               end
               parity: begin
                  state <= stop1;
                  so    <= 1'b1;
               end
               // line already high here
               stop1: begin
                  if (cfg_stop == stop_two) begin
                     state <= stop2;
                  end else begin
                     state <= idle;
                  end
               end
               default: begin
                  state <= idle;
                  so    <= 1'b1;
               end
            endcase
         end
      end
   end

   // every path into idle leaves the line at mark
   a_idle_high: assert property (@(posedge app_clk) disable iff (!reset_n)
      (state == idle) |-> so);

endmodule

// File: source/uart_rx_fsm.sv
`timescale 1ns/1ps
// receive machine on the 16x baud enable
// needs 8 ticks of low to accept a start bit
// fifo space is checked once per frame at start acceptance
// a frame seen with a full fifo is dropped with one overrun pulse

module uart_rx_fsm
   import uart_cfg_pkg::*, uart_data_pkg::*;
(
   input  logic         app_clk,
   input  logic         reset_n,
   input  logic         baud_tick,
   input  logic         cfg_rx_enable,
   input  stop_mode_t   cfg_stop,
   input  parity_mode_t cfg_parity,
   input  logic         si,
   output logic         wr_valid,
   input  logic         wr_ready,
   output rx_entry_t    wr_data,
   output logic         rx_overrun
);

   typedef enum logic [2:0] {idle, start, data, parity, stop1, stop2} rx_state_t;

   rx_state_t  state;
   logic       si_meta;
   logic       si_s;
   // ticks since the last sample point
   logic [3:0] tick_cnt;
   logic [2:0] bit_cnt;
   uart_byte_t data_q;
   // frame owns a fifo slot
   logic       keep_q;
   logic       par_err_q;
   logic       frm_err_q;
   logic       sample;
   logic       last_stop;
   logic       frm_err;
   rx_err_t    err_code;

   //////////////////////////////
   // line synchroniser
   //////////////////////////////

   // two flops, both at mark level in reset
   always_ff @(posedge app_clk) begin
      if (!reset_n) begin
         si_meta <= 1'b1;
         si_s    <= 1'b1;
      end else begin
         si_meta <= si;
         si_s    <= si_meta;
      end
   end

   //////////////////////////////
   // sample point and fifo word
   //////////////////////////////

   // bit centre is 16 ticks after the previous one
   assign sample    = baud_tick && (tick_cnt == 4'd15);
   assign last_stop = (state == stop2) || ((state == stop1) && (cfg_stop == stop_one));
   // include the stop bit being sampled right now
   assign frm_err   = frm_err_q || !si_s;
   assign err_code  = frm_err ? err_frame : (par_err_q ? err_parity : err_none);
   assign wr_valid  = sample && last_stop && keep_q;
   assign wr_data   = {err_code, data_q};

   // data shifts in lsb first
   always_ff @(posedge app_clk) begin
      if (sample && (state == data)) begin
         data_q <= {si_s, data_q[7:1]};
      end
   end

   //////////////////////////////
   // frame state machine
   //////////////////////////////

   always_ff @(posedge app_clk) begin
      if (!reset_n) begin
         state      <= idle;
         tick_cnt   <= '0;
         bit_cnt    <= '0;
         keep_q     <= 1'b0;
         par_err_q  <= 1'b0;
         frm_err_q  <= 1'b0;
         rx_overrun <= 1'b0;
      end else begin
         rx_overrun <= 1'b0;
         if (baud_tick) begin
            tick_cnt <= tick_cnt + 4'd1;
            case (state)
               idle: begin
                  // first low tick counts as tick one of eight
                  if (cfg_rx_enable && !si_s) begin
                     state    <= start;
                     tick_cnt <= '0;
                  end
               end
               start: begin
                  if (si_s) begin
                     // glitch
                     state <= idle;
                  end else if (tick_cnt == 4'd6) begin
                     state      <= data;
                     tick_cnt   <= '0;
                     bit_cnt    <= '0;
                     keep_q     <= wr_ready;
                     rx_overrun <= !wr_ready;
                     par_err_q  <= 1'b0;
                     frm_err_q  <= 1'b0;
                  end
               end
               data: begin
                  if (sample) begin
                     bit_cnt <= bit_cnt + 3'd1;
                     if (bit_cnt == 3'd7) begin
                        if (cfg_parity == par_none) begin
                           state <= stop1;
                        end else begin
                           state <= parity;
                        end
                     end
                  end
               end
               parity: begin
                  if (sample) begin
                     // expected bit is the data xor plus one for odd
                     if (si_s != (^data_q ^ (cfg_parity == par_odd))) begin
                        par_err_q <= 1'b1;
                     end
                     state <= stop1;
                  end
               end
               stop1: begin
                  if (sample) begin
                     frm_err_q <= frm_err;
                     if (cfg_stop == stop_two) begin
                        state <= stop2;
                     end else begin
                        state <= idle;
                     end
                  end
               end
               stop2: begin
                  if (sample) begin
                     state <= idle;
                  end
               end
               default: state <= idle;
            endcase
         end
      end
   end

   // slot reserved at start acceptance and nothing else fills the fifo
   a_wr_accepted: assert property (@(posedge app_clk) disable iff (!reset_n)
      wr_valid |-> wr_ready);

endmodule

// File: source/uart_sync_fifo.sv
`timescale 1ns/1ps
// single clock fifo with valid/ready on both sides
// DEPTH must be a power of two and at least 2
// flags are registered and follow a transfer by one cycle

module uart_sync_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 8
) (
   input  logic             app_clk,
   input  logic             reset_n,
   input  logic             in_valid,
   output logic             in_ready,
   input  logic [WIDTH-1:0] in_data,
   output logic             out_valid,
   input  logic             out_ready,
   output logic [WIDTH-1:0] out_data
);

   localparam int AW = $clog2(DEPTH);

   logic [WIDTH-1:0] mem [DEPTH];
   // pointers carry one extra wrap bit
   logic [AW:0]      wr_ptr;
   logic [AW:0]      rd_ptr;
   logic [AW:0]      wr_ptr_nxt;
   logic [AW:0]      rd_ptr_nxt;
   logic [AW:0]      fill;
   logic             push;
   logic             pop;

   assign push       = in_valid && in_ready;
   assign pop        = out_valid && out_ready;
   assign wr_ptr_nxt = wr_ptr + {{AW{1'b0}}, push};
   assign rd_ptr_nxt = rd_ptr + {{AW{1'b0}}, pop};
   // occupancy seen by the flags
   assign fill       = wr_ptr - rd_ptr;

   always_ff @(posedge app_clk) begin
      if (!reset_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         // held low through reset
         in_ready  <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         wr_ptr    <= wr_ptr_nxt;
         rd_ptr    <= rd_ptr_nxt;
         // full when only the wrap bit differs
         in_ready  <= (wr_ptr_nxt ^ rd_ptr_nxt) != {1'b1, {AW{1'b0}}};
         out_valid <= wr_ptr_nxt != rd_ptr_nxt;
      end
   end

   // storage
   always_ff @(posedge app_clk) begin
      if (push) begin
         mem[wr_ptr[AW-1:0]] <= in_data;
      end
   end

   // head of queue
   assign out_data = mem[rd_ptr[AW-1:0]];

   // registered flags must agree with the pointers
   a_no_write_full: assert property (@(posedge app_clk) disable iff (!reset_n)
      push |-> fill != (AW+1)'(DEPTH));
   a_no_read_empty: assert property (@(posedge app_clk) disable iff (!reset_n)
      pop |-> fill != '0);

endmodule

// File: source/uart_baud_gen.sv
`timescale 1ns/1ps
// 16x baud enable as a one cycle pulse on app_clk
// a new divisor is picked up at the next reload
// divisor zero gives a tick on every cycle

module uart_baud_gen
   import uart_cfg_pkg::*;
(
   input  logic      app_clk,
   input  logic      reset_n,
   input  baud_div_t cfg_baud_div,
   output logic      baud_tick
);

   // cycles left until the next tick
   baud_div_t div_cnt;

   ////////////////////////////
   // divisor down counter
   ////////////////////////////

   always_ff @(posedge app_clk) begin
      if (!reset_n) begin
         // restart so first tick comes one cycle after reset
         div_cnt   <= '0;
         baud_tick <= 1'b0;
      end else if (div_cnt == '0) begin
         // reload and fire
         div_cnt   <= cfg_baud_div;
         baud_tick <= 1'b1;
      end else begin
         div_cnt   <= div_cnt - 16'd1;
         baud_tick <= 1'b0;
      end
   end

   // period check
   // counter runs div..0 so ticks are div plus one cycles apart

endmodule

// File: source/uart_data_pkg.sv
// data path types for the transmit and receive streams
// receive fifo word keeps the error code above the byte

package uart_data_pkg;

   // one character on the line
   typedef logic [7:0] uart_byte_t;

   ////////////////////////////
   // receive status
   ////////////////////////////

   // framing wins over parity when a frame has both
   typedef enum logic [1:0] {
      err_none   = 2'b00,
      err_frame  = 2'b01,
      err_parity = 2'b10
   } rx_err_t;

   // receive fifo word
   // [9:8] error code
   // [7:0] received byte
   typedef logic [9:0] rx_entry_t;

endpackage

// File: source/uart_cfg_pkg.sv
// frame format settings for both line directions
// encodings match the legacy control field values
// baud divisor is integer only so no fractional rates

package uart_cfg_pkg;

   ////////////////////////////
   // parity
   ////////////////////////////

   // bit 1 enables parity and bit 0 selects the odd sense
   // even parity bit equals the xor of the eight data bits
   typedef enum logic [1:0] {
      par_none = 2'b00,
      par_even = 2'b10,
      par_odd  = 2'b11
   } parity_mode_t;

   ////////////////////////////
   // stop bits and baud
   ////////////////////////////

   // number of stop bits after data or parity
   typedef enum logic {
      stop_one = 1'b0,
      stop_two = 1'b1
   } stop_mode_t;

   // 16x tick period is this value plus one app_clk cycles
   typedef logic [15:0] baud_div_t;

endpackage
